// ==== axil_core_bridge.sv ====
`timescale 1ns/1ns

module axil_core_bridge (
  input  logic             m_axi_aclk_i,
  input  logic             m_axi_aresetn_i,
  // core request port
  input  logic             req_i,
  input  logic             req_we_i,
  input  axil_pkg::addr_t  req_addr_i,
  input  axil_pkg::data_t  req_wdata_i,
  input  axil_pkg::strb_t  req_wstrb_i,
  output logic             busy_o,
  output logic             done_o,
  output axil_pkg::data_t  done_rdata_o,
  output axil_pkg::resp_t  done_resp_o,
  // towards the master
  output logic             start_read_o,
  output logic             start_write_o,
  output axil_pkg::addr_t  addr_o,
  output axil_pkg::data_t  wdata_o,
  output axil_pkg::strb_t  wstrb_o,
  // from the master
  input  logic             rd_done_i,
  input  logic             wr_done_i,
  input  axil_pkg::data_t  rdata_i,
  input  axil_pkg::resp_t  rresp_i,
  input  axil_pkg::resp_t  bresp_i
);

  logic busy_q;
  logic pending_we_q;
  logic accept;

  // only the done strobe of the access in flight ends it
  assign done_o = busy_q && (pending_we_q ? wr_done_i : rd_done_i);

  // busy falls in the done cycle so a back-to-back request is taken
  assign busy_o = busy_q && !done_o;

  // requests made while busy are dropped here
  assign accept = req_i && !busy_o;

  assign start_read_o  = accept && !req_we_i;
  assign start_write_o = accept && req_we_i;

  // the master samples these only with a start strobe
  assign addr_o  = req_addr_i;
  assign wdata_o = req_wdata_i;
  assign wstrb_o = req_wstrb_i;

  // writes report zero data
  assign done_rdata_o = pending_we_q ? '0 : rdata_i;
  assign done_resp_o  = pending_we_q ? bresp_i : rresp_i;

  always_ff @(posedge m_axi_aclk_i, negedge m_axi_aresetn_i)
  begin
    if (!m_axi_aresetn_i)
    begin
      busy_q       <= 1'b0;
      pending_we_q <= 1'b0;
    end
    else if (accept)
    begin
      busy_q       <= 1'b1;
      pending_we_q <= req_we_i;
    end
    else if (done_o)
    begin
      busy_q <= 1'b0;
    end
  end

endmodule

// ==== axil_master.sv ====
`timescale 1ns/1ns

module axil_master (
  input  logic             m_axi_aclk_i,
  input  logic             m_axi_aresetn_i,
  // read address channel
  output axil_pkg::addr_t  m_axi_araddr_o,
  output logic [2:0]       m_axi_arprot_o,
  output logic             m_axi_arvalid_o,
  input  logic             m_axi_arready_i,
  // read data channel
  input  axil_pkg::data_t  m_axi_rdata_i,
  input  axil_pkg::resp_t  m_axi_rresp_i,
  input  logic             m_axi_rvalid_i,
  output logic             m_axi_rready_o,
  // write address channel
  output axil_pkg::addr_t  m_axi_awaddr_o,
  output logic [2:0]       m_axi_awprot_o,
  output logic             m_axi_awvalid_o,
  input  logic             m_axi_awready_i,
  // write data channel
  output axil_pkg::data_t  m_axi_wdata_o,
  output axil_pkg::strb_t  m_axi_wstrb_o,
  output logic             m_axi_wvalid_o,
  input  logic             m_axi_wready_i,
  // write response channel
  input  axil_pkg::resp_t  m_axi_bresp_i,
  input  logic             m_axi_bvalid_i,
  output logic             m_axi_bready_o,
  // command side
  input  logic             start_read_i,
  input  axil_pkg::addr_t  raddr_i,
  input  logic             start_write_i,
  input  axil_pkg::addr_t  wraddr_i,
  input  axil_pkg::data_t  wrdata_i,
  input  axil_pkg::strb_t  wstrb_i,
  output axil_pkg::data_t  rdata_o,
  output axil_pkg::resp_t  rresp_o,
  output logic             rd_done_o,
  output axil_pkg::resp_t  bresp_o,
  output logic             wr_done_o
);

  axil_pkg::wr_state_t wr_state_q;
  axil_pkg::rd_state_t rd_state_q;
  logic                aw_done;
  logic                w_done;
  logic                b_hs;
  logic                r_hs;

  // plain data accesses only
  assign m_axi_arprot_o = 3'b000;
  assign m_axi_awprot_o = 3'b000;

  // a channel is finished once its valid is gone or its handshake is on this edge
  assign aw_done = !m_axi_awvalid_o || m_axi_awready_i;
  assign w_done  = !m_axi_wvalid_o || m_axi_wready_i;
  assign b_hs    = m_axi_bvalid_i && m_axi_bready_o;
  assign r_hs    = m_axi_rvalid_i && m_axi_rready_o;

  ////////////////////////////////////////////////////////////////////////////
  // write path
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge m_axi_aclk_i, negedge m_axi_aresetn_i)
  begin
    if (!m_axi_aresetn_i)
    begin
      wr_state_q      <= axil_pkg::WR_IDLE;
      m_axi_awvalid_o <= 1'b0;
      m_axi_wvalid_o  <= 1'b0;
      m_axi_bready_o  <= 1'b0;
      wr_done_o       <= 1'b0;
    end
    else
    begin
      wr_done_o <= 1'b0;
      case (wr_state_q)
        axil_pkg::WR_IDLE:
          if (start_write_i)
          begin
            m_axi_awvalid_o <= 1'b1;
            m_axi_wvalid_o  <= 1'b1;
            m_axi_bready_o  <= 1'b1;
            wr_state_q      <= axil_pkg::WR_ADDR_DATA;
          end
        axil_pkg::WR_ADDR_DATA:
        begin
          // AW and W retire independently
          if (m_axi_awready_i)
            m_axi_awvalid_o <= 1'b0;
          if (m_axi_wready_i)
            m_axi_wvalid_o <= 1'b0;
          if (aw_done && w_done)
            wr_state_q <= axil_pkg::WR_RESP;
        end
        axil_pkg::WR_RESP:
          if (b_hs)
          begin
            m_axi_bready_o <= 1'b0;
            wr_done_o      <= 1'b1;
            wr_state_q     <= axil_pkg::WR_IDLE;
          end
        default:
          wr_state_q <= axil_pkg::WR_IDLE;
      endcase
    end
  end

  // write payload is held from the start strobe until the handshakes
  always_ff @(posedge m_axi_aclk_i)
  begin
    if ((wr_state_q == axil_pkg::WR_IDLE) && start_write_i)
    begin
      m_axi_awaddr_o <= wraddr_i;
      m_axi_wdata_o  <= wrdata_i;
      m_axi_wstrb_o  <= wstrb_i;
    end
    if ((wr_state_q == axil_pkg::WR_RESP) && b_hs)
      bresp_o <= m_axi_bresp_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // read path
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge m_axi_aclk_i, negedge m_axi_aresetn_i)
  begin
    if (!m_axi_aresetn_i)
    begin
      rd_state_q      <= axil_pkg::RD_IDLE;
      m_axi_arvalid_o <= 1'b0;
      m_axi_rready_o  <= 1'b0;
      rd_done_o       <= 1'b0;
    end
    else
    begin
      rd_done_o <= 1'b0;
      case (rd_state_q)
        axil_pkg::RD_IDLE:
          if (start_read_i)
          begin
            m_axi_arvalid_o <= 1'b1;
            m_axi_rready_o  <= 1'b1;
            rd_state_q      <= axil_pkg::RD_ADDR;
          end
        axil_pkg::RD_ADDR:
          if (m_axi_arready_i)
          begin
            m_axi_arvalid_o <= 1'b0;
            rd_state_q      <= axil_pkg::RD_DATA;
          end
        axil_pkg::RD_DATA:
          if (r_hs)
          begin
            m_axi_rready_o <= 1'b0;
            rd_done_o      <= 1'b1;
            rd_state_q     <= axil_pkg::RD_IDLE;
          end
        default:
          rd_state_q <= axil_pkg::RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge m_axi_aclk_i)
  begin
    if ((rd_state_q == axil_pkg::RD_IDLE) && start_read_i)
      m_axi_araddr_o <= raddr_i;
    // result is captured on the R handshake
    if ((rd_state_q == axil_pkg::RD_DATA) && r_hs)
    begin
      rdata_o <= m_axi_rdata_i;
      rresp_o <= m_axi_rresp_i;
    end
  end

endmodule

// ==== axil_pkg.sv ====
package axil_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // bus payload types
  ////////////////////////////////////////////////////////////////////////////

  // byte address as issued by the core
  typedef logic [31:0] addr_t;

  // the core is 32-bit, so the data bus is fixed at one word
  typedef logic [31:0] data_t;

  // one enable bit per byte of data_t
  typedef logic [3:0] strb_t;

  typedef logic [1:0] resp_t;

  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_SLVERR = 2'd2;

  ////////////////////////////////////////////////////////////////////////////
  // state machines
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_ADDR_DATA,
    WR_RESP
  } wr_state_t;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ADDR,
    RD_DATA
  } rd_state_t;

  typedef enum logic [1:0] {
    S_IDLE,
    S_WAIT,
    S_WRITE_RESP,
    S_READ_DATA
  } slv_state_t;

endpackage

// ==== axil_properties.sv ====
`timescale 1ns/1ns

module axil_properties (
  input  logic             m_axi_aclk_i,
  input  logic             m_axi_aresetn_i,
  input  axil_pkg::addr_t  araddr_i,
  input  logic             arvalid_i,
  input  logic             arready_i,
  input  axil_pkg::addr_t  awaddr_i,
  input  logic             awvalid_i,
  input  logic             awready_i,
  input  axil_pkg::data_t  wdata_i,
  input  axil_pkg::strb_t  wstrb_i,
  input  logic             wvalid_i,
  input  logic             wready_i,
  input  logic             rready_i,
  input  logic             bready_i,
  input  logic             start_read_i,
  input  logic             start_write_i,
  input  logic             rd_done_i,
  input  logic             wr_done_i
);

  logic rd_open_q;
  logic wr_open_q;

  // a start is taken only while the path is idle, i.e. rready or bready low
  always_ff @(posedge m_axi_aclk_i, negedge m_axi_aresetn_i)
  begin
    if (!m_axi_aresetn_i)
    begin
      rd_open_q <= 1'b0;
      wr_open_q <= 1'b0;
    end
    else
    begin
      if (start_read_i && !rready_i)
        rd_open_q <= 1'b1;
      else if (rd_done_i)
        rd_open_q <= 1'b0;
      if (start_write_i && !bready_i)
        wr_open_q <= 1'b1;
      else if (wr_done_i)
        wr_open_q <= 1'b0;
    end
  end

  valid_low_in_reset: assert property (@(posedge m_axi_aclk_i)
    !m_axi_aresetn_i |-> !arvalid_i && !awvalid_i && !wvalid_i)
    else $error("AXI valid high during reset");

  ar_hold: assert property (@(posedge m_axi_aclk_i) disable iff (!m_axi_aresetn_i)
    arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i))
    else $error("arvalid or araddr changed before the AR handshake");

  aw_hold: assert property (@(posedge m_axi_aclk_i) disable iff (!m_axi_aresetn_i)
    awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i))
    else $error("awvalid or awaddr changed before the AW handshake");

  w_hold: assert property (@(posedge m_axi_aclk_i) disable iff (!m_axi_aresetn_i)
    wvalid_i && !wready_i |=> wvalid_i && $stable(wdata_i) && $stable(wstrb_i))
    else $error("wvalid or write payload changed before the W handshake");

  // each done clears its open flag, so a second one needs a new start
  rd_done_once: assert property (@(posedge m_axi_aclk_i) disable iff (!m_axi_aresetn_i)
    rd_done_i |-> rd_open_q)
    else $error("read done without an open read");

  wr_done_once: assert property (@(posedge m_axi_aclk_i) disable iff (!m_axi_aresetn_i)
    wr_done_i |-> wr_open_q)
    else $error("write done without an open write");

endmodule

bind axil_master axil_properties u_properties (
  .m_axi_aclk_i    (m_axi_aclk_i),
  .m_axi_aresetn_i (m_axi_aresetn_i),
  .araddr_i        (m_axi_araddr_o),
  .arvalid_i       (m_axi_arvalid_o),
  .arready_i       (m_axi_arready_i),
  .awaddr_i        (m_axi_awaddr_o),
  .awvalid_i       (m_axi_awvalid_o),
  .awready_i       (m_axi_awready_i),
  .wdata_i         (m_axi_wdata_o),
  .wstrb_i         (m_axi_wstrb_o),
  .wvalid_i        (m_axi_wvalid_o),
  .wready_i        (m_axi_wready_i),
  .rready_i        (m_axi_rready_o),
  .bready_i        (m_axi_bready_o),
  .start_read_i    (start_read_i),
  .start_write_i   (start_write_i),
  .rd_done_i       (rd_done_o),
  .wr_done_i       (wr_done_o)
);

// ==== axil_ram_slave.sv ====
`timescale 1ns/1ns

module axil_ram_slave #(
  parameter int MEM_ADDR_BITS = 8,
  parameter int READY_DELAY   = 2
) (
  input  logic             m_axi_aclk_i,
  input  logic             m_axi_aresetn_i,
  // read address channel
  input  axil_pkg::addr_t  s_axi_araddr_i,
  input  logic [2:0]       s_axi_arprot_i,
  input  logic             s_axi_arvalid_i,
  output logic             s_axi_arready_o,
  // read data channel
  output axil_pkg::data_t  s_axi_rdata_o,
  output axil_pkg::resp_t  s_axi_rresp_o,
  output logic             s_axi_rvalid_o,
  input  logic             s_axi_rready_i,
  // write address channel
  input  axil_pkg::addr_t  s_axi_awaddr_i,
  input  logic [2:0]       s_axi_awprot_i,
  input  logic             s_axi_awvalid_i,
  output logic             s_axi_awready_o,
  // write data channel
  input  axil_pkg::data_t  s_axi_wdata_i,
  input  axil_pkg::strb_t  s_axi_wstrb_i,
  input  logic             s_axi_wvalid_i,
  output logic             s_axi_wready_o,
  // write response channel
  output axil_pkg::resp_t  s_axi_bresp_o,
  output logic             s_axi_bvalid_o,
  input  logic             s_axi_bready_i
);

  localparam int WORDS = 2 ** MEM_ADDR_BITS;
  localparam int CNT_W = (READY_DELAY > 0) ? $clog2(READY_DELAY + 1) : 1;
  localparam logic [CNT_W-1:0] DELAY_CNT = CNT_W'(READY_DELAY);

  axil_pkg::slv_state_t     state_q;
  logic [CNT_W-1:0]         cnt_q;
  logic                     op_rd_q;
  logic                     cur_rd;
  logic                     go;
  logic                     accept_rd;
  logic                     accept_wr;
  axil_pkg::addr_t          acc_addr;
  logic [MEM_ADDR_BITS-1:0] word_idx;
  logic                     addr_ok;

  // RAM powers up cleared
  axil_pkg::data_t mem [WORDS] = '{default: '0};

  // reads win when both directions show up in the same idle cycle
  assign cur_rd = (state_q == axil_pkg::S_IDLE) ? s_axi_arvalid_i : op_rd_q;

  always_comb
  begin
    case (state_q)
      axil_pkg::S_IDLE:
        go = (s_axi_arvalid_i || (s_axi_awvalid_i && s_axi_wvalid_i)) && (READY_DELAY == 0);
      axil_pkg::S_WAIT:
        go = (cnt_q == DELAY_CNT);
      default:
        go = 1'b0;
    endcase
  end

  assign accept_rd = go && cur_rd;
  assign accept_wr = go && !cur_rd;

  // AW and W are taken together in a single cycle
  assign s_axi_arready_o = accept_rd;
  assign s_axi_awready_o = accept_wr;
  assign s_axi_wready_o  = accept_wr;

  assign s_axi_rvalid_o = (state_q == axil_pkg::S_READ_DATA);
  assign s_axi_bvalid_o = (state_q == axil_pkg::S_WRITE_RESP);

  assign acc_addr = cur_rd ? s_axi_araddr_i : s_axi_awaddr_i;
  assign word_idx = acc_addr[MEM_ADDR_BITS+1:2];

  // only addresses inside the RAM are served
  assign addr_ok = (acc_addr[31:MEM_ADDR_BITS+2] == '0);

  always_ff @(posedge m_axi_aclk_i, negedge m_axi_aresetn_i)
  begin
    if (!m_axi_aresetn_i)
    begin
      state_q <= axil_pkg::S_IDLE;
      cnt_q   <= '0;
      op_rd_q <= 1'b0;
    end
    else
    begin
      case (state_q)
        axil_pkg::S_IDLE:
          if (go)
            state_q <= accept_rd ? axil_pkg::S_READ_DATA : axil_pkg::S_WRITE_RESP;
          else if (s_axi_arvalid_i || (s_axi_awvalid_i && s_axi_wvalid_i))
          begin
            state_q <= axil_pkg::S_WAIT;
            cnt_q   <= CNT_W'(1);
            op_rd_q <= s_axi_arvalid_i;
          end
        axil_pkg::S_WAIT:
          if (go)
            state_q <= op_rd_q ? axil_pkg::S_READ_DATA : axil_pkg::S_WRITE_RESP;
          else
            cnt_q <= cnt_q + 1'b1;
        axil_pkg::S_READ_DATA:
          if (s_axi_rready_i)
            state_q <= axil_pkg::S_IDLE;
        axil_pkg::S_WRITE_RESP:
          if (s_axi_bready_i)
            state_q <= axil_pkg::S_IDLE;
        default:
          state_q <= axil_pkg::S_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // RAM and response registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge m_axi_aclk_i)
  begin
    if (accept_rd)
    begin
      s_axi_rdata_o <= addr_ok ? mem[word_idx] : '0;
      s_axi_rresp_o <= addr_ok ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
    end
    if (accept_wr)
    begin
      s_axi_bresp_o <= addr_ok ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
      // rejected writes leave the RAM untouched
      if (addr_ok)
        for (int b = 0; b < 4; b++)
          if (s_axi_wstrb_i[b])
            mem[word_idx][8*b +: 8] <= s_axi_wdata_i[8*b +: 8];
    end
  end

endmodule

// ==== axil_subsystem_top.sv ====
`timescale 1ns/1ns

module axil_subsystem_top #(
  parameter int MEM_ADDR_BITS = 8,
  parameter int READY_DELAY   = 2
) (
  input  logic             m_axi_aclk_i,
  input  logic             m_axi_aresetn_i,
  input  logic             req_i,
  input  logic             req_we_i,
  input  axil_pkg::addr_t  req_addr_i,
  input  axil_pkg::data_t  req_wdata_i,
  input  axil_pkg::strb_t  req_wstrb_i,
  output logic             busy_o,
  output logic             done_o,
  output axil_pkg::data_t  done_rdata_o,
  output axil_pkg::resp_t  done_resp_o
);

  // bridge to master
  logic            start_read;
  logic            start_write;
  axil_pkg::addr_t cmd_addr;
  axil_pkg::data_t cmd_wdata;
  axil_pkg::strb_t cmd_wstrb;
  logic            rd_done;
  logic            wr_done;
  axil_pkg::data_t rdata;
  axil_pkg::resp_t rresp;
  axil_pkg::resp_t bresp;

  // AXI4-Lite between master and slave
  axil_pkg::addr_t araddr;
  logic [2:0]      arprot;
  logic            arvalid;
  logic            arready;
  axil_pkg::data_t axi_rdata;
  axil_pkg::resp_t axi_rresp;
  logic            rvalid;
  logic            rready;
  axil_pkg::addr_t awaddr;
  logic [2:0]      awprot;
  logic            awvalid;
  logic            awready;
  axil_pkg::data_t wdata;
  axil_pkg::strb_t wstrb;
  logic            wvalid;
  logic            wready;
  axil_pkg::resp_t axi_bresp;
  logic            bvalid;
  logic            bready;

  axil_core_bridge u_bridge (
    .m_axi_aclk_i    (m_axi_aclk_i),
    .m_axi_aresetn_i (m_axi_aresetn_i),
    .req_i           (req_i),
    .req_we_i        (req_we_i),
    .req_addr_i      (req_addr_i),
    .req_wdata_i     (req_wdata_i),
    .req_wstrb_i     (req_wstrb_i),
    .busy_o          (busy_o),
    .done_o          (done_o),
    .done_rdata_o    (done_rdata_o),
    .done_resp_o     (done_resp_o),
    .start_read_o    (start_read),
    .start_write_o   (start_write),
    .addr_o          (cmd_addr),
    .wdata_o         (cmd_wdata),
    .wstrb_o         (cmd_wstrb),
    .rd_done_i       (rd_done),
    .wr_done_i       (wr_done),
    .rdata_i         (rdata),
    .rresp_i         (rresp),
    .bresp_i         (bresp)
  );

  axil_master u_master (
    .m_axi_aclk_i    (m_axi_aclk_i),
    .m_axi_aresetn_i (m_axi_aresetn_i),
    .m_axi_araddr_o  (araddr),
    .m_axi_arprot_o  (arprot),
    .m_axi_arvalid_o (arvalid),
    .m_axi_arready_i (arready),
    .m_axi_rdata_i   (axi_rdata),
    .m_axi_rresp_i   (axi_rresp),
    .m_axi_rvalid_i  (rvalid),
    .m_axi_rready_o  (rready),
    .m_axi_awaddr_o  (awaddr),
    .m_axi_awprot_o  (awprot),
    .m_axi_awvalid_o (awvalid),
    .m_axi_awready_i (awready),
    .m_axi_wdata_o   (wdata),
    .m_axi_wstrb_o   (wstrb),
    .m_axi_wvalid_o  (wvalid),
    .m_axi_wready_i  (wready),
    .m_axi_bresp_i   (axi_bresp),
    .m_axi_bvalid_i  (bvalid),
    .m_axi_bready_o  (bready),
    .start_read_i    (start_read),
    .raddr_i         (cmd_addr),
    .start_write_i   (start_write),
    .wraddr_i        (cmd_addr),
    .wrdata_i        (cmd_wdata),
    .wstrb_i         (cmd_wstrb),
    .rdata_o         (rdata),
    .rresp_o         (rresp),
    .rd_done_o       (rd_done),
    .bresp_o         (bresp),
    .wr_done_o       (wr_done)
  );

  axil_ram_slave #(
    .MEM_ADDR_BITS (MEM_ADDR_BITS),
    .READY_DELAY   (READY_DELAY)
  ) u_slave (
    .m_axi_aclk_i    (m_axi_aclk_i),
    .m_axi_aresetn_i (m_axi_aresetn_i),
    .s_axi_araddr_i  (araddr),
    .s_axi_arprot_i  (arprot),
    .s_axi_arvalid_i (arvalid),
    .s_axi_arready_o (arready),
    .s_axi_rdata_o   (axi_rdata),
    .s_axi_rresp_o   (axi_rresp),
    .s_axi_rvalid_o  (rvalid),
    .s_axi_rready_i  (rready),
    .s_axi_awaddr_i  (awaddr),
    .s_axi_awprot_i  (awprot),
    .s_axi_awvalid_i (awvalid),
    .s_axi_awready_o (awready),
    .s_axi_wdata_i   (wdata),
    .s_axi_wstrb_i   (wstrb),
    .s_axi_wvalid_i  (wvalid),
    .s_axi_wready_o  (wready),
    .s_axi_bresp_o   (axi_bresp),
    .s_axi_bvalid_o  (bvalid),
    .s_axi_bready_i  (bready)
  );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
TOP=tb_axil_subsystem

rm -rf "$BUILD_DIR"

verilator --binary --timing --assert \
  -f sources.f \
  --top-module "$TOP" \
  -Mdir "$BUILD_DIR" \
  -o "$TOP"
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Verification passed" "$LOG"; then
  echo "simulation result: pass"
  exit 0
else
  echo "simulation result: fail"
  exit 1
fi

// ==== sources.f ====
axil_pkg.sv
axil_master.sv
axil_core_bridge.sv
axil_ram_slave.sv
axil_subsystem_top.sv
axil_properties.sv
tb_axil_subsystem.sv

// ==== tb_axil_subsystem.sv ====
`timescale 1ns/1ns

module tb_axil_subsystem;

  localparam int unsigned SEED = 32'h9fbd8152;
  localparam int MEM_WORDS   = 256;
  localparam int CLK_PERIOD  = 40;
  localparam int WAIT_CYCLES = 40;
  // write then read back, four times
  localparam int BASIC_TXN   = 8;
  // sixteen full-word seeds, each overwritten by a partial write and read back
  localparam int STRB_TXN    = 48;
  // four rounds of seed write, bad write, bad read, good read
  localparam int RANGE_TXN   = 16;
  localparam int RANDOM_TXN  = 300;
  localparam int NUM_TXN     = BASIC_TXN + STRB_TXN + RANGE_TXN + RANDOM_TXN;

  logic            aclk;
  logic            aresetn;
  logic            req;
  logic            req_we;
  axil_pkg::addr_t req_addr;
  axil_pkg::data_t req_wdata;
  axil_pkg::strb_t req_wstrb;
  logic            busy;
  logic            done;
  axil_pkg::data_t done_rdata;
  axil_pkg::resp_t done_resp;

  axil_pkg::data_t ref_mem [MEM_WORDS];
  int              req_count;
  int              done_count;
  int              errors;

  axil_subsystem_top dut (
    .m_axi_aclk_i    (aclk),
    .m_axi_aresetn_i (aresetn),
    .req_i           (req),
    .req_we_i        (req_we),
    .req_addr_i      (req_addr),
    .req_wdata_i     (req_wdata),
    .req_wstrb_i     (req_wstrb),
    .busy_o          (busy),
    .done_o          (done),
    .done_rdata_o    (done_rdata),
    .done_resp_o     (done_resp)
  );

  always #(CLK_PERIOD / 2) aclk = ~aclk;

  // done_o only moves on the rising edge
  always @(negedge aclk)
  begin
    if (done)
      done_count++;
  end

  initial
  begin
    #(NUM_TXN * WAIT_CYCLES * CLK_PERIOD);
    stop_with_failure("timeout: the run did not finish in the time allowed");
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks and reference model
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Verification failed");
    $fatal(1, "stopping the run");
  endtask

  task automatic check_data(input string name, input axil_pkg::data_t actual,
                            input axil_pkg::data_t expected);
    if (actual !== expected)
      stop_with_failure($sformatf("error: %s = 0x%08h, expected 0x%08h",
                                  name, actual, expected));
  endtask

  task automatic check_resp(input string name, input axil_pkg::resp_t actual,
                            input axil_pkg::resp_t expected);
    if (actual !== expected)
      stop_with_failure($sformatf("error: %s = 0x%01h, expected 0x%01h",
                                  name, actual, expected));
  endtask

  // words live at address bits 9:2, anything above bit 9 is outside the RAM
  task automatic update_model(input logic we, input axil_pkg::addr_t addr,
                              input axil_pkg::data_t wdata, input axil_pkg::strb_t wstrb,
                              output axil_pkg::data_t exp_data,
                              output axil_pkg::resp_t exp_resp);
    logic [7:0] idx;
    logic       in_range;
    idx      = addr[9:2];
    in_range = (addr[31:10] == '0);
    exp_resp = in_range ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
    exp_data = '0;
    if (we && in_range)
    begin
      for (int b = 0; b < 4; b++)
        if (wstrb[b])
          ref_mem[idx][8*b +: 8] = wdata[8*b +: 8];
    end
    else if (!we && in_range)
      exp_data = ref_mem[idx];
  endtask

  function automatic axil_pkg::addr_t rand_addr(input logic outside);
    axil_pkg::addr_t a;
    logic [31:0]     upper;
    a      = $urandom();
    upper  = $urandom();
    a[1:0] = 2'b00;
    if (!outside)
      a[31:10] = '0;
    else
    begin
      if (upper[21:0] == '0)
        upper[0] = 1'b1;
      a[31:10] = upper[21:0];
    end
    return a;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // one request on the core port
  ////////////////////////////////////////////////////////////////////////////

  task automatic do_access(input logic we, input axil_pkg::addr_t addr,
                           input axil_pkg::data_t wdata, input axil_pkg::strb_t wstrb);
    axil_pkg::data_t exp_data;
    axil_pkg::resp_t exp_resp;
    int              cycles;
    cycles = 0;
    @(negedge aclk);
    req       = 1'b1;
    req_we    = we;
    req_addr  = addr;
    req_wdata = wdata;
    req_wstrb = wstrb;
    req_count++;
    @(negedge aclk);
    req = 1'b0;
    while (!done && cycles < WAIT_CYCLES)
    begin
      if (!busy)
        stop_with_failure("busy_o went low while a request was still open");
      @(negedge aclk);
      cycles++;
    end
    if (!done)
      stop_with_failure("no done_o came back for an open request");
    else
    begin
      update_model(we, addr, wdata, wstrb, exp_data, exp_resp);
      check_data("done_rdata_o", done_rdata, exp_data);
      check_resp("done_resp_o", done_resp, exp_resp);
    end
  endtask

  initial
  begin
    axil_pkg::addr_t in_addr;
    axil_pkg::addr_t out_addr;
    logic [31:0]     rnd;
    aclk       = 1'b0;
    aresetn    = 1'b0;
    req        = 1'b0;
    req_we     = 1'b0;
    req_addr   = '0;
    req_wdata  = '0;
    req_wstrb  = '0;
    req_count  = 0;
    done_count = 0;
    errors     = 0;
    void'($urandom(SEED));
    for (int i = 0; i < MEM_WORDS; i++)
      ref_mem[i] = '0;
    repeat (2) @(negedge aclk);
    aresetn = 1'b1;

    // idle bus after reset
    repeat (5)
    begin
      @(negedge aclk);
      if (busy || done)
        stop_with_failure("busy_o or done_o went high with no request made");
    end

    for (int i = 0; i < BASIC_TXN / 2; i++)
    begin
      in_addr = rand_addr(1'b0);
      do_access(1'b1, in_addr, $urandom(), 4'hf);
      do_access(1'b0, in_addr, '0, '0);
    end

    // a full word first, so the bytes left alone are not zero
    for (int i = 0; i < STRB_TXN / 3; i++)
    begin
      in_addr = rand_addr(1'b0);
      do_access(1'b1, in_addr, $urandom(), 4'hf);
      rnd     = $urandom();
      do_access(1'b1, in_addr, $urandom(), rnd[3:0]);
      do_access(1'b0, in_addr, '0, '0);
    end

    // out-of-range addresses alias an in-range word in their low bits
    for (int i = 0; i < RANGE_TXN / 4; i++)
    begin
      in_addr  = rand_addr(1'b0);
      out_addr = rand_addr(1'b1);
      out_addr[9:0] = in_addr[9:0];
      do_access(1'b1, in_addr, $urandom(), 4'hf);
      do_access(1'b1, out_addr, $urandom(), 4'hf);
      do_access(1'b0, out_addr, '0, '0);
      do_access(1'b0, in_addr, '0, '0);
    end

    for (int i = 0; i < RANDOM_TXN; i++)
    begin
      rnd = $urandom();
      do_access(rnd[0], rand_addr(rnd[3:2] == 2'b11), $urandom(), rnd[7:4]);
    end

    // give a stray extra done_o time to show up
    repeat (5) @(negedge aclk);
    if (done_count != req_count)
    begin
      $display("done_o pulsed %0d times for %0d requests", done_count, req_count);
      errors++;
    end
    if (errors == 0)
    begin
      $display("Verification passed");
      $finish;
    end
    else
      stop_with_failure("the done_o count does not match the requests");
  end

endmodule
